/* build.f */
+incdir+rtl
rtl/videoPostProcessPkg.sv
rtl/videoTimingGen.sv
rtl/pixelFifo.sv
rtl/outputStartGate.sv
rtl/videoPostProcess.sv
verification/videoPostProcess_properties.sv
verification/tbVideoPostProcess.sv

/* Makefile */
# Verilator flow for the video output stage

VERILATOR ?= verilator
TOP       ?= tbVideoPostProcess
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Verification passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verification/tbVideoPostProcess.sv */
/*
 * Testbench for the video output stage
 * LFSR pixel source, raster reference model, in-order pixel and flag checks
 */
`timescale 1ns/1ps
`include "videoPostProcess_settings.svh"

module tbVideoPostProcess;
	import videoPostProcessPkg::*;

	localparam int lpHTotal    = `VPP_H_TOTAL;
	localparam int lpVTotal    = `VPP_V_TOTAL;
	localparam int lpFrameLen  = lpHTotal * lpVTotal;
	localparam int lpFullLevel = `VPP_FIFO_DEPTH - `VPP_FULL_MARGIN;
	localparam int lpWaitLimit = 20000;

	logic     iFCLK;
	logic     iFRST;
	pixelT    i_pixel;
	logic     i_pixelValid;
	logic     o_full;
	logic     o_overflow;
	logic     o_underflow;
	videoOutT o_video;

	logic [15:0] lfsrState;
	logic [1:0]  sourceMode;
	logic        monitorOn;
	logic        started;
	logic        underflowSeen;
	pixelT       expQueue [$];
	int          acceptCount;
	int          deCount;
	int          rasterPos;
	int          frameCount;
	int          startWait;

	videoPostProcess u_dut (
		.iFCLK        (iFCLK),
		.iFRST        (iFRST),
		.i_pixel      (i_pixel),
		.i_pixelValid (i_pixelValid),
		.o_full       (o_full),
		.o_overflow   (o_overflow),
		.o_underflow  (o_underflow),
		.o_video      (o_video)
	);

	initial
	begin
		iFCLK = 1'b0;
		forever #2 iFCLK = ~iFCLK;
	end

	// ------------------------------------------------------------
	// Random source and reference model
	// ------------------------------------------------------------
	// 16-bit Fibonacci LFSR, taps 16 14 13 11
	function automatic logic lfsrStep();
		logic fb;
		fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
		lfsrState = {lfsrState[14:0], fb};
		return fb;
	endfunction

	function automatic logic [15:0] lfsrBits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[14:0], lfsrStep()};
		return v;
	endfunction

	// Expected sync at raster position, zero is first active pixel
	function automatic syncT refSync(input int pos);
		int   h;
		int   v;
		syncT s;
		h    = pos % lpHTotal;
		v    = (pos / lpHTotal) % lpVTotal;
		s.de = (h < `VPP_H_ACTIVE) && (v < `VPP_V_ACTIVE);
		s.hs = (h >= `VPP_H_ACTIVE + `VPP_H_FRONT) &&
			(h < `VPP_H_ACTIVE + `VPP_H_FRONT + `VPP_H_SYNC);
		s.vs = (v >= `VPP_V_ACTIVE + `VPP_V_FRONT) &&
			(v < `VPP_V_ACTIVE + `VPP_V_FRONT + `VPP_V_SYNC);
		return s;
	endfunction

	// ------------------------------------------------------------
	// Compare tasks
	// ------------------------------------------------------------
	task automatic abortRun();
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic checkSync(input syncT got, input syncT exp, input string name);
		if (got !== exp)
		begin
			$display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkPixel(input pixelT got, input pixelT exp, input string name);
		if (got !== exp)
		begin
			$display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkFlag(input logic got, input logic exp, input string name);
		if (got !== exp)
		begin
			$display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
			abortRun();
		end
	endtask

	// ------------------------------------------------------------
	// Source driver
	// ------------------------------------------------------------
	// Mode 1 full rate, mode 2 with random gaps, else idle
	always @(posedge iFCLK)
	begin
		if (iFRST || sourceMode == 2'd0)
			i_pixelValid <= 1'b0;
		else
		begin
			i_pixel <= pixelT'(lfsrBits(16));
			if (sourceMode == 2'd1)
				i_pixelValid <= !o_full;
			else
				i_pixelValid <= (lfsrBits(2) != 2'd0) && !o_full;
		end
	end

	// ------------------------------------------------------------
	// Output monitor
	// ------------------------------------------------------------
	always @(posedge iFCLK)
	begin
		if (monitorOn)
		begin
			// First de due exactly when the start countdown expires
			if (!started)
				checkFlag(o_video.sync.de, startWait == 1, "o_video.sync.de");
			if (startWait > 0)
				startWait--;

			if (!started && !o_video.sync.de)
			begin
				// Startup hold, everything quiet
				checkSync(o_video.sync, '0, "o_video.sync");
				checkPixel(o_video.pixel, '0, "o_video.pixel");
				checkFlag(o_underflow, 1'b0, "o_underflow");
			end
			else
			begin
				started = 1'b1;
				checkSync(o_video.sync, refSync(rasterPos), "o_video.sync");
				frameCount = rasterPos / lpFrameLen;
				rasterPos++;
				if (o_video.sync.de)
				begin
					deCount++;
					if (expQueue.size() > 0)
					begin
						checkFlag(o_underflow, 1'b0, "o_underflow");
						checkPixel(o_video.pixel, expQueue.pop_front(), "o_video.pixel");
					end
					else
					begin
						// Starved read shows a zero pixel
						checkPixel(o_video.pixel, '0, "o_video.pixel");
						checkFlag(o_underflow, 1'b1, "o_underflow");
						underflowSeen = 1'b1;
					end
				end
				else
					checkPixel(o_video.pixel, '0, "o_video.pixel");
				if (underflowSeen)
					checkFlag(o_underflow, 1'b1, "o_underflow");
			end
			checkFlag(o_overflow, 1'b0, "o_overflow");

			// Level seen here counts fetches through the current de
			if (!underflowSeen)
				checkFlag(o_full, (acceptCount - deCount) >= lpFullLevel, "o_full");

			if (i_pixelValid && !o_full)
			begin
				acceptCount++;
				expQueue.push_back(i_pixel);
				// Gate, raster and FIFO read each add one cycle
				if (acceptCount == `VPP_START_LEVEL)
					startWait = 3;
			end
		end
	end

	// ------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------
	initial
	begin
		int cyc;
		iFRST         = 1'b1;
		i_pixel       = '0;
		i_pixelValid  = 1'b0;
		lfsrState     = 16'd80;
		sourceMode    = 2'd0;
		monitorOn     = 1'b0;
		started       = 1'b0;
		underflowSeen = 1'b0;
		acceptCount   = 0;
		deCount       = 0;
		rasterPos     = 0;
		frameCount    = 0;
		startWait     = 0;

		repeat (8) @(posedge iFCLK);
		iFRST      <= 1'b0;
		monitorOn  <= 1'b1;
		sourceMode <= 2'd1;

		// Full rate against back-pressure, then gappy, then source stops
		repeat (600) @(posedge iFCLK);
		sourceMode <= 2'd2;
		repeat (600) @(posedge iFCLK);
		sourceMode <= 2'd0;

		for (cyc = 0; cyc < lpWaitLimit && !underflowSeen; cyc++)
			@(posedge iFCLK);
		if (!underflowSeen)
		begin
			$display("Timed out waiting for the FIFO to run dry");
			abortRun();
		end

		// Sticky flag must hold across a few lines
		repeat (3 * lpHTotal) @(posedge iFCLK);

		monitorOn <= 1'b0;
		iFRST     <= 1'b1;
		repeat (8) @(posedge iFCLK);
		iFRST <= 1'b0;
		@(posedge iFCLK);
		@(posedge iFCLK);
		checkFlag(o_underflow, 1'b0, "o_underflow");
		checkFlag(o_overflow, 1'b0, "o_overflow");
		checkFlag(u_dut.timingRun, 1'b0, "timingRun");
		checkSync(o_video.sync, '0, "o_video.sync");
		checkPixel(o_video.pixel, '0, "o_video.pixel");

		if (frameCount >= 3)
		begin
			$display("Verification passed");
			$finish;
		end
		else
		begin
			$display("Fewer than three frames were shown before the FIFO ran dry");
			abortRun();
		end
	end

endmodule

/* verification/videoPostProcess_properties.sv */
/*
 * Bound assertions for the video output stage
 * Sync exclusivity, almost-full behaviour and sticky error flags
 */
`timescale 1ns/1ps
`include "videoPostProcess_settings.svh"

module videoPostProcessProperties (
	input logic                          iFCLK,
	input logic                          iFRST,
	input videoPostProcessPkg::videoOutT i_video,
	input logic                          i_full,
	input videoPostProcessPkg::fifoLevelT i_level,
	input logic                          i_overflow,
	input logic                          i_underflow
);
	import videoPostProcessPkg::*;

	localparam int lpFullLevel = `VPP_FIFO_DEPTH - `VPP_FULL_MARGIN;

	// No data enable inside sync
	assert property (@(posedge iFCLK) disable iff (iFRST)
		!(i_video.sync.de && (i_video.sync.hs || i_video.sync.vs)))
		else $error("de overlaps hs or vs");

	// Almost-full only drops as the level steps down from the threshold
	assert property (@(posedge iFCLK)
		$fell(i_full) |-> $past(iFRST) ||
			((int'($past(i_level)) == lpFullLevel) && (int'(i_level) == lpFullLevel - 1)))
		else $error("o_full fell without the level stepping below threshold");

	// Sticky flags clear only through reset
	assert property (@(posedge iFCLK) $fell(i_overflow) |-> $past(iFRST))
		else $error("o_overflow fell outside reset");

	assert property (@(posedge iFCLK) $fell(i_underflow) |-> $past(iFRST))
		else $error("o_underflow fell outside reset");

endmodule

bind videoPostProcess videoPostProcessProperties u_props (
	.iFCLK       (iFCLK),
	.iFRST       (iFRST),
	.i_video     (o_video),
	.i_full      (o_full),
	.i_level     (u_pixelFifo.level),
	.i_overflow  (o_overflow),
	.i_underflow (o_underflow)
);

/* rtl/videoPostProcess.sv */
/*
 * Video output stage top
 * Buffers a fast pixel stream and replays it under raster timing
 */
`timescale 1ns/1ps

module videoPostProcess (
	input  logic                          iFCLK,
	input  logic                          iFRST,
	input  videoPostProcessPkg::pixelT    i_pixel,
	input  logic                          i_pixelValid,
	output logic                          o_full,
	output logic                          o_overflow,
	output logic                          o_underflow,
	output videoPostProcessPkg::videoOutT o_video
);
	import videoPostProcessPkg::*;

	logic  pixelAccept;
	logic  timingRun;
	logic  fetch;
	syncT  timingSync;
	pixelT rdPixel;

	// ------------------------------------------------------------
	// Input side
	// ------------------------------------------------------------
	// Pixels taken only while almost-full is clear
	assign pixelAccept = i_pixelValid && !o_full;

	// Raster held until enough pixels are buffered
	outputStartGate u_startGate (
		.iFCLK       (iFCLK),
		.iFRST       (iFRST),
		.i_accept    (pixelAccept),
		.o_timingRun (timingRun)
	);

	pixelFifo u_pixelFifo (
		.iFCLK       (iFCLK),
		.iFRST       (iFRST),
		.i_wrPixel   (i_pixel),
		.i_write     (pixelAccept),
		.i_read      (fetch),
		.o_rdPixel   (rdPixel),
		.o_full      (o_full),
		.o_overflow  (o_overflow),
		.o_underflow (o_underflow)
	);

	// ------------------------------------------------------------
	// Display side
	// ------------------------------------------------------------
	// Fetch leads sync by one cycle, matching the FIFO read latency
	videoTimingGen u_timingGen (
		.iFCLK   (iFCLK),
		.iFRST   (iFRST),
		.i_run   (timingRun),
		.o_fetch (fetch),
		.o_sync  (timingSync)
	);

	// Sync and pixel already aligned, both registered
	assign o_video = {timingSync, rdPixel};

endmodule

/* rtl/outputStartGate.sv */
/*
 * Raster start gate
 * Keeps timing held until a start level of pixels has been accepted
 */
`timescale 1ns/1ps
`include "videoPostProcess_settings.svh"

module outputStartGate (
	input  logic iFCLK,
	input  logic iFRST,
	input  logic i_accept,
	output logic o_timingRun
);
	import videoPostProcessPkg::*;

	// Start level never exceeds FIFO depth, so the level type fits
	localparam fifoLevelT lpStartLevel = fifoLevelT'(`VPP_START_LEVEL);

	fifoLevelT acceptCount;
	logic      startReached;
	logic      countEn;

	// ------------------------------------------------------------
	// Accept counter
	// ------------------------------------------------------------
	assign startReached = (acceptCount == lpStartLevel);
	// Frozen once the level is met
	assign countEn      = i_accept && !o_timingRun && !startReached;

	always_ff @(posedge iFCLK)
	begin
		if (iFRST)
		begin
			acceptCount <= '0;
			o_timingRun <= 1'b0;
		end
		else
		begin
			if (countEn)
				acceptCount <= acceptCount + 1'b1;

			// Release raster one cycle after level reached, then hold
			if (startReached)
				o_timingRun <= 1'b1;
		end
	end

endmodule

/* rtl/pixelFifo.sv */
/*
 * Single-clock pixel FIFO
 * Almost-full flag with margin, registered read, sticky error flags
 */
`timescale 1ns/1ps
`include "videoPostProcess_settings.svh"

module pixelFifo (
	input  logic                       iFCLK,
	input  logic                       iFRST,
	input  videoPostProcessPkg::pixelT i_wrPixel,
	input  logic                       i_write,
	input  logic                       i_read,
	output videoPostProcessPkg::pixelT o_rdPixel,
	output logic                       o_full,
	output logic                       o_overflow,
	output logic                       o_underflow
);
	import videoPostProcessPkg::*;

	localparam int        lpDepth      = `VPP_FIFO_DEPTH;
	localparam int        lpPtrWidth   = $clog2(lpDepth);
	localparam fifoLevelT lpDepthLevel = fifoLevelT'(`VPP_FIFO_DEPTH);
	localparam fifoLevelT lpFullLevel  = fifoLevelT'(`VPP_FIFO_DEPTH - `VPP_FULL_MARGIN);

	pixelT                 fifoMem [0:lpDepth-1];
	logic [lpPtrWidth-1:0] wrPtr;
	logic [lpPtrWidth-1:0] rdPtr;
	fifoLevelT             level;
	logic                  empty;
	logic                  trueFull;
	logic                  push;
	logic                  pop;

	// ------------------------------------------------------------
	// Status and handshake
	// ------------------------------------------------------------
	assign empty    = (level == '0);
	assign trueFull = (level == lpDepthLevel);
	// Writes into a full buffer are dropped
	assign push     = i_write && !trueFull;
	assign pop      = i_read && !empty;

	// Early warning, source stalls with margin entries still free
	assign o_full   = (level >= lpFullLevel);

	// Storage
	always_ff @(posedge iFCLK)
	begin
		if (push)
			fifoMem[wrPtr] <= i_wrPixel;
	end

	// ------------------------------------------------------------
	// Pointers, level and read data
	// ------------------------------------------------------------
	always_ff @(posedge iFCLK)
	begin
		if (iFRST)
		begin
			wrPtr       <= '0;
			rdPtr       <= '0;
			level       <= '0;
			o_rdPixel   <= '0;
			o_overflow  <= 1'b0;
			o_underflow <= 1'b0;
		end
		else
		begin
			// Pointers wrap naturally, depth is a power of two
			if (push)
				wrPtr <= wrPtr + 1'b1;
			if (pop)
				rdPtr <= rdPtr + 1'b1;

			case ({push, pop})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level;
			endcase

			// Zero pixel when idle or starved
			if (pop)
				o_rdPixel <= fifoMem[rdPtr];
			else
				o_rdPixel <= '0;

			// Sticky until reset
			if (i_write && trueFull)
				o_overflow <= 1'b1;
			if (i_read && empty)
				o_underflow <= 1'b1;
		end
	end

endmodule

/* rtl/videoTimingGen.sv */
/*
 * Raster timing generator
 * Walks active, front porch, sync and back porch per line and frame,
 * with a fetch strobe one cycle ahead of data enable
 */
`timescale 1ns/1ps
`include "videoPostProcess_settings.svh"

module videoTimingGen (
	input  logic                      iFCLK,
	input  logic                      iFRST,
	input  logic                      i_run,
	output logic                      o_fetch,
	output videoPostProcessPkg::syncT o_sync
);
	import videoPostProcessPkg::*;

	// ------------------------------------------------------------
	// Counter widths and region boundaries
	// ------------------------------------------------------------
	localparam int lpHWidth = $clog2(`VPP_H_TOTAL);
	localparam int lpVWidth = $clog2(`VPP_V_TOTAL);

	// Horizontal marks, sized to the counter
	localparam logic [lpHWidth-1:0] lpHActive    = lpHWidth'(`VPP_H_ACTIVE);
	localparam logic [lpHWidth-1:0] lpHSyncStart = lpHWidth'(`VPP_H_ACTIVE + `VPP_H_FRONT);
	localparam logic [lpHWidth-1:0] lpHSyncEnd   =
		lpHWidth'(`VPP_H_ACTIVE + `VPP_H_FRONT + `VPP_H_SYNC);
	localparam logic [lpHWidth-1:0] lpHLast      = lpHWidth'(`VPP_H_TOTAL - 1);

	// Vertical marks, in lines
	localparam logic [lpVWidth-1:0] lpVActive    = lpVWidth'(`VPP_V_ACTIVE);
	localparam logic [lpVWidth-1:0] lpVSyncStart = lpVWidth'(`VPP_V_ACTIVE + `VPP_V_FRONT);
	localparam logic [lpVWidth-1:0] lpVSyncEnd   =
		lpVWidth'(`VPP_V_ACTIVE + `VPP_V_FRONT + `VPP_V_SYNC);
	localparam logic [lpVWidth-1:0] lpVLast      = lpVWidth'(`VPP_V_TOTAL - 1);

	logic [lpHWidth-1:0] hCount;
	logic [lpVWidth-1:0] vCount;
	logic                lineEnd;
	logic                frameEnd;
	logic                hActive;
	logic                vActive;
	logic                hSyncZone;
	logic                vSyncZone;
	syncT                syncNext;

	// ------------------------------------------------------------
	// Raster counters
	// ------------------------------------------------------------
	assign lineEnd  = (hCount == lpHLast);
	assign frameEnd = (vCount == lpVLast);

	// Parked on first active pixel of frame 0 until run
	always_ff @(posedge iFCLK)
	begin
		if (iFRST || !i_run)
		begin
			hCount <= '0;
			vCount <= '0;
		end
		else
		begin
			// Pixel position within the line
			if (lineEnd)
				hCount <= '0;
			else
				hCount <= hCount + 1'b1;

			// Line advances at end of each line
			if (lineEnd)
			begin
				if (frameEnd)
					vCount <= '0;
				else
					vCount <= vCount + 1'b1;
			end
		end
	end

	// ------------------------------------------------------------
	// Region decode
	// ------------------------------------------------------------
	// Active region first, so counter zero is visible video
	assign hActive   = (hCount < lpHActive);
	assign vActive   = (vCount < lpVActive);
	assign hSyncZone = (hCount >= lpHSyncStart) && (hCount < lpHSyncEnd);
	assign vSyncZone = (vCount >= lpVSyncStart) && (vCount < lpVSyncEnd);

	// Early strobe, reads the FIFO one cycle before display
	assign o_fetch = i_run && hActive && vActive;

	always_comb
	begin
		syncNext    = '0;
		syncNext.de = o_fetch;
		// hs repeats on every line, blanking lines included
		syncNext.hs = i_run && hSyncZone;
		syncNext.vs = i_run && vSyncZone;
	end

	// ------------------------------------------------------------
	// Sync output register
	// ------------------------------------------------------------
	// One cycle behind fetch, lines up with the FIFO read data
	always_ff @(posedge iFCLK)
	begin
		if (iFRST || !i_run)
			o_sync <= '0;
		else
			o_sync <= syncNext;
	end

endmodule

/* rtl/videoPostProcessPkg.sv */
/*
 * Video post-process shared types
 * Pixel, sync and output words plus the FIFO level count
 */
`include "videoPostProcess_settings.svh"

package videoPostProcessPkg;

	// ------------------------------------------------------------
	// Pixel word
	// ------------------------------------------------------------
	// YUYV stream, chroma alternates U and V per pixel
	typedef struct packed {
		logic [7:0] chroma;
		logic [7:0] luma;
	} pixelT;

	// ------------------------------------------------------------
	// Raster sync
	// ------------------------------------------------------------
	// All active high
	typedef struct packed {
		logic vs;
		logic hs;
		logic de;
	} syncT;

	// Output word toward the display transmitter
	typedef struct packed {
		syncT  sync;
		pixelT pixel;
	} videoOutT;

	// ------------------------------------------------------------
	// FIFO fill count
	// ------------------------------------------------------------
	// One bit wider than the pointers so a full FIFO is representable
	typedef logic [$clog2(`VPP_FIFO_DEPTH + 1)-1:0] fifoLevelT;

endpackage

/* rtl/videoPostProcess_settings.svh */
/*
 * Video post-process build settings
 * Raster geometry, pixel FIFO sizing and raster start level
 */
`ifndef VIDEOPOSTPROCESS_SETTINGS_SVH
`define VIDEOPOSTPROCESS_SETTINGS_SVH

// ------------------------------------------------------------
// Horizontal timing, in pixels
// ------------------------------------------------------------
`define VPP_H_ACTIVE    16
`define VPP_H_FRONT     2
`define VPP_H_SYNC      3
`define VPP_H_BACK      4
`define VPP_H_TOTAL     (`VPP_H_ACTIVE + `VPP_H_FRONT + `VPP_H_SYNC + `VPP_H_BACK)

// ------------------------------------------------------------
// Vertical timing, in lines
// ------------------------------------------------------------
`define VPP_V_ACTIVE    6
`define VPP_V_FRONT     1
`define VPP_V_SYNC      2
`define VPP_V_BACK      2
`define VPP_V_TOTAL     (`VPP_V_ACTIVE + `VPP_V_FRONT + `VPP_V_SYNC + `VPP_V_BACK)

// ------------------------------------------------------------
// Pixel buffering
// ------------------------------------------------------------
// Depth must stay a power of two
`define VPP_FIFO_DEPTH  64
// Free entries left when almost-full rises
`define VPP_FULL_MARGIN 4
// One full line buffered before raster starts
`define VPP_START_LEVEL 16

`endif
